//--- common/aznable_pkg.sv
`default_nettype none

package aznable_pkg;

	// plain vector types
	typedef logic [7:0] byte_t;
	typedef logic [15:0] addr_t;
	typedef logic [16:0] dn_addr_t;
	typedef logic [8:0] pos_t;
	// packed as {blue, green, red}
	typedef logic [23:0] rgb_t;
	typedef logic [15:0] timer_t;

	// memory sizes
	localparam int PGROM_AW = 15;
	localparam int WKRAM_AW = 14;

	// CPU address map
	localparam addr_t ADDR_IN0 = 16'h8000;
	localparam addr_t ADDR_VIDEO_CTL = 16'h8001;
	localparam byte_t PAGE_JOYSTICK = 8'h81;
	localparam byte_t PAGE_PS2_KEY = 8'h86;
	localparam byte_t PAGE_TIMESTAMP = 8'h88;
	localparam byte_t PAGE_TIMER = 8'h89;
	localparam addr_t ADDR_PAUSE = 16'h8A30;
	localparam addr_t ADDR_MENU = 16'h8A40;
	// work RAM fills 0xC000 to 0xFFFF
	localparam logic [1:0] WKRAM_BASE_BITS = 2'b11;

	// download index of the program ROM
	localparam byte_t DN_INDEX_PGROM = 8'd0;

	// 320x240 raster in 6 MHz pixel clocks
	localparam pos_t H_VISIBLE = 9'd320;
	localparam pos_t H_TOTAL = 9'd384;
	localparam pos_t H_SYNC_START = 9'd336;
	localparam pos_t H_SYNC_LEN = 9'd32;
	localparam pos_t V_VISIBLE = 9'd240;
	localparam pos_t V_TOTAL = 9'd264;
	localparam pos_t V_SYNC_START = 9'd244;
	localparam pos_t V_SYNC_LEN = 9'd4;

	// millisecond tick from clk_24
	localparam int MS_DIVIDER = 24000;
	localparam int MS_PRESCALE_W = 15;

	// 6 devices, 32 buttons each
	localparam int JOY_BYTES = 24;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		addr_t adr;
		byte_t dat;
	} wb_req_t;

	typedef struct packed {
		byte_t dat;
		logic ack;
	} wb_rsp_t;

	typedef struct packed {
		dn_addr_t addr;
		byte_t data;
		logic wr;
		byte_t index;
	} dn_req_t;

	typedef struct packed {
		rgb_t rgb;
		logic a;
	} layer_pix_t;

	typedef struct packed {
		logic hs;
		logic vs;
		logic hb;
		logic vb;
		rgb_t rgb;
	} video_out_t;

	typedef struct packed {
		pos_t hcnt;
		pos_t vcnt;
		logic hs;
		logic vs;
		logic hb;
		logic vb;
	} raster_t;

	// one-cycle write strobes towards the control registers
	typedef struct packed {
		logic video_ctl;
		logic pause;
		logic menu;
		logic timer_clear;
		byte_t data;
	} ctl_wr_t;

	typedef enum logic {
		BUS_IDLE,
		BUS_ACK
	} bus_state_t;

endpackage

`default_nettype wire

//--- files.f
common/aznable_pkg.sv
memory/dpram.sv
video/video_timer.sv
video/layer_mixer.sv
hdl/bus_fabric.sv
hdl/input_ports.sv
hdl/system_control.sv
hdl/aznable_system.sv
tests/tb_aznable_system.sv

//--- hdl/aznable_system.sv
`timescale 1ns/1ps
`default_nettype none

module aznable_system (
	input wire logic clk_24,
	input wire logic rst,
	input wire logic ce_6,
	input wire logic pause,
	input wire logic menu,
	input wire aznable_pkg::dn_req_t dn,
	input wire aznable_pkg::wb_req_t wb_in,
	input wire logic [aznable_pkg::JOY_BYTES*8-1:0] joystick,
	input wire logic [10:0] ps2_key,
	input wire logic [32:0] timestamp,
	input wire aznable_pkg::layer_pix_t char_pix,
	input wire aznable_pkg::layer_pix_t sprite_pix,
	input wire aznable_pkg::layer_pix_t tile_pix,
	input wire aznable_pkg::rgb_t star_rgb,
	output aznable_pkg::wb_rsp_t wb_out,
	output aznable_pkg::video_out_t video,
	output logic pause_system
);
	import aznable_pkg::*;

	addr_t ram_addr;
	logic wkram_we;
	ctl_wr_t ctl_wr;
	byte_t pgrom_q;
	byte_t wkram_q;
	byte_t io_q;
	logic menu_flag;
	logic sprite_high;
	raster_t raster;
	logic pgrom_dn_we;

	// only index 0 of the download stream lands in the program ROM
	assign pgrom_dn_we = dn.wr && (dn.index == DN_INDEX_PGROM);

	bus_fabric fabric (
		.clk_24(clk_24),
		.rst(rst),
		.wb_in(wb_in),
		.pgrom_q(pgrom_q),
		.wkram_q(wkram_q),
		.io_q(io_q),
		.menu_flag(menu_flag),
		.wb_out(wb_out),
		.ram_addr(ram_addr),
		.wkram_we(wkram_we),
		.ctl_wr(ctl_wr)
	);

	input_ports inputs (
		.clk_24(clk_24),
		.rst(rst),
		.addr(ram_addr),
		.raster(raster),
		.menu(menu),
		.timer_clear(ctl_wr.timer_clear),
		.joystick(joystick),
		.ps2_key(ps2_key),
		.timestamp(timestamp),
		.io_q(io_q)
	);

	system_control sysctl (
		.clk_24(clk_24),
		.rst(rst),
		.pause(pause),
		.menu(menu),
		.ctl_wr(ctl_wr),
		.sprite_high(sprite_high),
		.pause_system(pause_system),
		.menu_flag(menu_flag)
	);

	// program ROM 0x0000 - 0x7FFF, CPU side is read-only
	dpram #(.AW(PGROM_AW), .DW($bits(byte_t))) pgrom (
		.clk_24(clk_24),
		.a_addr(ram_addr[PGROM_AW-1:0]),
		.a_we(1'b0),
		.a_din(8'h00),
		.a_q(pgrom_q),
		.b_addr(dn.addr[PGROM_AW-1:0]),
		.b_we(pgrom_dn_we),
		.b_din(dn.data),
		.b_q()
	);

	// work RAM 0xC000 - 0xFFFF
	dpram #(.AW(WKRAM_AW), .DW($bits(byte_t))) wkram (
		.clk_24(clk_24),
		.a_addr(ram_addr[WKRAM_AW-1:0]),
		.a_we(wkram_we),
		.a_din(wb_in.dat),
		.a_q(wkram_q),
		.b_addr({WKRAM_AW{1'b0}}),
		.b_we(1'b0),
		.b_din(8'h00),
		.b_q()
	);

	video_timer vtimer (
		.clk_24(clk_24),
		.rst(rst),
		.ce_6(ce_6),
		.raster(raster)
	);

	layer_mixer mixer (
		.clk_24(clk_24),
		.rst(rst),
		.raster(raster),
		.char_pix(char_pix),
		.sprite_pix(sprite_pix),
		.tile_pix(tile_pix),
		.star_rgb(star_rgb),
		.sprite_high(sprite_high),
		.video(video)
	);

endmodule

`default_nettype wire

//--- hdl/bus_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fabric (
	input wire logic clk_24,
	input wire logic rst,
	input wire aznable_pkg::wb_req_t wb_in,
	input wire aznable_pkg::byte_t pgrom_q,
	input wire aznable_pkg::byte_t wkram_q,
	input wire aznable_pkg::byte_t io_q,
	input wire logic menu_flag,
	output aznable_pkg::wb_rsp_t wb_out,
	output aznable_pkg::addr_t ram_addr,
	output logic wkram_we,
	output aznable_pkg::ctl_wr_t ctl_wr
);
	import aznable_pkg::*;

	bus_state_t state;
	logic ack_q;
	byte_t dat_q;
	byte_t rd_byte;
	logic req;
	logic wr;
	logic pgrom_sel;
	logic wkram_sel;
	logic menu_sel;

	// the ack guard keeps a held stb from starting a second access
	assign req = (state == BUS_IDLE) && wb_in.cyc && wb_in.stb && !ack_q;
	assign wr = req && wb_in.we;

	// region decode
	assign pgrom_sel = !wb_in.adr[15];
	assign wkram_sel = wb_in.adr[15:14] == WKRAM_BASE_BITS;
	assign menu_sel = wb_in.adr == ADDR_MENU;

	// RAMs see the address straight away, so read data is ready one edge later
	assign ram_addr = wb_in.adr;
	assign wkram_we = wr && wkram_sel;

	assign ctl_wr.video_ctl = wr && (wb_in.adr == ADDR_VIDEO_CTL);
	assign ctl_wr.pause = wr && (wb_in.adr == ADDR_PAUSE);
	assign ctl_wr.menu = wr && menu_sel;
	assign ctl_wr.timer_clear = wr && (wb_in.adr[15:8] == PAGE_TIMER);
	assign ctl_wr.data = wb_in.dat;

	// input_ports returns 0 for anything it does not map
	always_comb
	begin
		if (pgrom_sel)
			rd_byte = pgrom_q;
		else if (wkram_sel)
			rd_byte = wkram_q;
		else if (menu_sel)
			rd_byte = {8{menu_flag}};
		else
			rd_byte = io_q;
	end

	always_ff @(posedge clk_24)
	begin
		if (rst)
		begin
			state <= BUS_IDLE;
			ack_q <= 1'b0;
		end
		else
		begin
			case (state)
				BUS_IDLE:
				begin
					ack_q <= 1'b0;
					if (req)
						state <= BUS_ACK;
				end
				BUS_ACK:
				begin
					ack_q <= 1'b1;
					state <= BUS_IDLE;
				end
				default:
					state <= BUS_IDLE;
			endcase
		end
	end

	// read byte travels with ack
	always_ff @(posedge clk_24)
	begin
		if (state == BUS_ACK)
			dat_q <= rd_byte;
	end

	assign wb_out = '{dat: dat_q, ack: ack_q};

	ack_single: assert property (@(posedge clk_24) disable iff (rst) ack_q |=> !ack_q);
	ack_in_cycle: assert property (@(posedge clk_24) disable iff (rst) ack_q |-> $past(wb_in.cyc));

endmodule

`default_nettype wire

//--- hdl/input_ports.sv
`timescale 1ns/1ps
`default_nettype none

module input_ports (
	input wire logic clk_24,
	input wire logic rst,
	input wire aznable_pkg::addr_t addr,
	input wire aznable_pkg::raster_t raster,
	input wire logic menu,
	input wire logic timer_clear,
	input wire logic [aznable_pkg::JOY_BYTES*8-1:0] joystick,
	input wire logic [10:0] ps2_key,
	input wire logic [32:0] timestamp,
	output aznable_pkg::byte_t io_q
);
	import aznable_pkg::*;

	logic [MS_PRESCALE_W-1:0] prescale;
	timer_t timer;
	logic [255:0] joy_ext;
	logic [15:0] ps2_ext;
	logic [63:0] ts_ext;
	byte_t status_byte;

	// millisecond counter, restarted by a write to the timer page
	always_ff @(posedge clk_24)
	begin
		if (rst || timer_clear)
		begin
			prescale <= '0;
			timer <= '0;
		end
		else if (prescale == MS_PRESCALE_W'(MS_DIVIDER - 1))
		begin
			prescale <= '0;
			timer <= timer + 16'd1;
		end
		else
			prescale <= prescale + MS_PRESCALE_W'(1);
	end

	// zero padding makes the bytes past each bus read as 0
	assign joy_ext = 256'(joystick);
	assign ps2_ext = 16'(ps2_key);
	// byte 4 carries only the toggle bit
	assign ts_ext = 64'(timestamp);

	assign status_byte = {raster.hs, raster.vs, raster.hb, raster.vb, 2'b10, menu, 1'b0};

	always_comb
	begin
		if (addr == ADDR_IN0)
			io_q = status_byte;
		else
		begin
			case (addr[15:8])
				PAGE_JOYSTICK: io_q = joy_ext[{addr[4:0], 3'd0} +: 8];
				PAGE_PS2_KEY: io_q = ps2_ext[{addr[0], 3'd0} +: 8];
				PAGE_TIMESTAMP: io_q = ts_ext[{addr[2:0], 3'd0} +: 8];
				PAGE_TIMER: io_q = timer[{addr[0], 3'd0} +: 8];
				default: io_q = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/system_control.sv
`timescale 1ns/1ps
`default_nettype none

module system_control (
	input wire logic clk_24,
	input wire logic rst,
	input wire logic pause,
	input wire logic menu,
	input wire aznable_pkg::ctl_wr_t ctl_wr,
	output logic sprite_high,
	output logic pause_system,
	output logic menu_flag
);
	import aznable_pkg::*;

	byte_t video_control;
	logic pause_trigger;

	always_ff @(posedge clk_24)
	begin
		if (rst)
			video_control <= '0;
		else if (ctl_wr.video_ctl)
			video_control <= ctl_wr.data;
	end

	// bit 0 puts sprites above the character map
	assign sprite_high = video_control[0];

	// software pause holds until the host pulses pause
	always_ff @(posedge clk_24)
	begin
		if (rst)
			pause_trigger <= 1'b0;
		else
		begin
			if (ctl_wr.pause)
				pause_trigger <= 1'b1;
			if (pause)
				pause_trigger <= 1'b0;
		end
	end

	assign pause_system = pause || pause_trigger;

	// the CPU acknowledges a menu request by writing ADDR_MENU
	always_ff @(posedge clk_24)
	begin
		if (rst)
			menu_flag <= 1'b0;
		else
		begin
			if (menu)
				menu_flag <= 1'b1;
			if (ctl_wr.menu)
				menu_flag <= 1'b0;
		end
	end

	pause_release: assert property (@(posedge clk_24) disable iff (rst)
		pause |-> pause_system ##1 !pause_trigger);

endmodule

`default_nettype wire

//--- memory/dpram.sv
`timescale 1ns/1ps
`default_nettype none

module dpram #(
	parameter int AW = 8,
	parameter int DW = 8
) (
	input wire logic clk_24,
	input wire logic [AW-1:0] a_addr,
	input wire logic a_we,
	input wire logic [DW-1:0] a_din,
	output logic [DW-1:0] a_q,
	input wire logic [AW-1:0] b_addr,
	input wire logic b_we,
	input wire logic [DW-1:0] b_din,
	output logic [DW-1:0] b_q
);

	logic [DW-1:0] mem [0:(1 << AW)-1];

	// both ports read the old contents on a write to the same word
	// port b wins when both write one address
	always_ff @(posedge clk_24)
	begin
		if (a_we)
			mem[a_addr] <= a_din;
		if (b_we)
			mem[b_addr] <= b_din;
		a_q <= mem[a_addr];
		b_q <= mem[b_addr];
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_aznable_system -f files.f -o tb_aznable_system
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output="$(./obj_dir/tb_aznable_system)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q -x -F "Done: no errors"; then
	exit 0
fi
exit 1

//--- tests/tb_aznable_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aznable_system;
	import aznable_pkg::*;

	localparam int ACK_TIMEOUT = 64;
	localparam int FRAME_TIMEOUT = 1000000;

	logic clk_24;
	logic rst;
	logic ce_6;
	logic pause;
	logic menu;
	dn_req_t dn;
	wb_req_t wb_in;
	logic [JOY_BYTES*8-1:0] joystick;
	logic [10:0] ps2_key;
	logic [32:0] timestamp;
	layer_pix_t char_pix;
	layer_pix_t sprite_pix;
	layer_pix_t tile_pix;
	rgb_t star_rgb;
	wb_rsp_t wb_out;
	video_out_t video;
	logic pause_system;

	logic [31:0] lfsr;
	logic [1:0] ce_phase;
	logic hung;
	int errors;
	int timeouts;
	int cycle_count = 0;
	byte_t pgrom_model [0:(1 << PGROM_AW)-1];
	byte_t wkram_model [0:(1 << WKRAM_AW)-1];
	addr_t addr_list [$];

	aznable_system uut (
		.clk_24(clk_24),
		.rst(rst),
		.ce_6(ce_6),
		.pause(pause),
		.menu(menu),
		.dn(dn),
		.wb_in(wb_in),
		.joystick(joystick),
		.ps2_key(ps2_key),
		.timestamp(timestamp),
		.char_pix(char_pix),
		.sprite_pix(sprite_pix),
		.tile_pix(tile_pix),
		.star_rgb(star_rgb),
		.wb_out(wb_out),
		.video(video),
		.pause_system(pause_system)
	);

	initial clk_24 = 1'b0;
	always #10 clk_24 = ~clk_24;

	always @(posedge clk_24)
		cycle_count <= cycle_count + 1;

	// pixel enable on every fourth clock
	always @(posedge clk_24)
	begin
		#2;
		ce_phase = ce_phase + 2'd1;
		ce_6 = (ce_phase == 2'd0);
	end

	// fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic rgb_t mix_model(input logic sh, input layer_pix_t c,
		input layer_pix_t s, input layer_pix_t t, input rgb_t st);
		if (sh && s.a)
			return s.rgb;
		if (c.a)
			return c.rgb;
		if (s.a)
			return s.rgb;
		if (t.a)
			return t.rgb;
		return st;
	endfunction

	task automatic next_cycle();
		@(posedge clk_24);
		#2;
	endtask

	// one Wishbone classic access, started 2 ns after an edge
	task automatic wb_access(input logic we, input addr_t adr, input byte_t dat,
		output byte_t q);
		int n;
		q = '0;
		if (hung)
			return;
		wb_in = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		n = 0;
		next_cycle();
		while (!wb_out.ack && n < ACK_TIMEOUT)
		begin
			next_cycle();
			n++;
		end
		if (wb_out.ack)
			q = wb_out.dat;
		else
		begin
			$display("timeout: no bus ack for the access to address %h", adr);
			timeouts++;
			hung = 1'b1;
		end
		wb_in = '0;
	endtask

	task automatic wb_write(input addr_t adr, input byte_t dat);
		byte_t unused_q;
		wb_access(1'b1, adr, dat, unused_q);
	endtask

	task automatic dn_write(input addr_t a, input byte_t d, input byte_t idx);
		dn = '{addr: dn_addr_t'(a), data: d, wr: 1'b1, index: idx};
		next_cycle();
		dn.wr = 1'b0;
	endtask

	task automatic test_pgrom();
		addr_t a;
		byte_t d;
		byte_t q;
		addr_list.delete();
		for (int i = 0; i < 32; i++)
		begin
			a = addr_t'(rand_bits(PGROM_AW));
			d = byte_t'(rand_bits(8));
			dn_write(a, d, DN_INDEX_PGROM);
			pgrom_model[a[PGROM_AW-1:0]] = d;
			// other download indexes must not reach the ROM
			dn_write(a, byte_t'(rand_bits(8)), byte_t'(rand_bits(8)) | 8'h01);
			addr_list.push_back(a);
		end
		foreach (addr_list[i])
		begin
			wb_write(addr_list[i], byte_t'(rand_bits(8)));
			wb_access(1'b0, addr_list[i], 8'h00, q);
			if (!hung && q !== pgrom_model[addr_list[i][PGROM_AW-1:0]])
			begin
				$display("ERR pgrom expected %h actual %h",
					pgrom_model[addr_list[i][PGROM_AW-1:0]], q);
				errors++;
			end
		end
	endtask

	task automatic test_wkram();
		addr_t a;
		byte_t d;
		byte_t q;
		addr_list.delete();
		for (int i = 0; i < 48; i++)
		begin
			a = 16'hC000 | addr_t'(rand_bits(WKRAM_AW));
			d = byte_t'(rand_bits(8));
			wb_write(a, d);
			wkram_model[a[WKRAM_AW-1:0]] = d;
			addr_list.push_back(a);
		end
		foreach (addr_list[i])
		begin
			wb_access(1'b0, addr_list[i], 8'h00, q);
			if (!hung && q !== wkram_model[addr_list[i][WKRAM_AW-1:0]])
			begin
				$display("ERR wkram expected %h actual %h",
					wkram_model[addr_list[i][WKRAM_AW-1:0]], q);
				errors++;
			end
		end
		// pages 0x8B to 0xBF hold nothing
		for (int i = 0; i < 16; i++)
		begin
			a = {8'h8B + byte_t'(rand_bits(8) % 53), byte_t'(rand_bits(8))};
			wb_access(1'b0, a, 8'h00, q);
			if (!hung && q !== 8'h00)
			begin
				$display("ERR unmapped expected %h actual %h", 8'h00, q);
				errors++;
			end
		end
	endtask

	task automatic test_inputs();
		byte_t q;
		byte_t exp;
		int off;
		for (int r = 0; r < 4; r++)
		begin
			for (int w = 0; w < JOY_BYTES / 4; w++)
				joystick[w*32 +: 32] = rand_bits(32);
			ps2_key = 11'(rand_bits(11));
			timestamp = {1'(rand_bits(1)), rand_bits(32)};
			menu = 1'(rand_bits(1));
			wb_access(1'b0, ADDR_IN0, 8'h00, q);
			if (!hung && q[3:0] !== {2'b10, menu, 1'b0})
			begin
				$display("ERR in0 expected %h actual %h", {2'b10, menu, 1'b0}, q[3:0]);
				errors++;
			end
			for (int i = 0; i < 8; i++)
			begin
				off = int'(rand_bits(8));
				exp = ((off % 32) < JOY_BYTES) ? joystick[(off % 32)*8 +: 8] : 8'h00;
				wb_access(1'b0, {PAGE_JOYSTICK, byte_t'(off)}, 8'h00, q);
				if (!hung && q !== exp)
				begin
					$display("ERR joystick expected %h actual %h", exp, q);
					errors++;
				end
				exp = (off % 2 == 1) ? {5'd0, ps2_key[10:8]} : ps2_key[7:0];
				wb_access(1'b0, {PAGE_PS2_KEY, byte_t'(off)}, 8'h00, q);
				if (!hung && q !== exp)
				begin
					$display("ERR ps2_key expected %h actual %h", exp, q);
					errors++;
				end
				// byte 4 is the toggle bit alone
				if (off % 8 < 4)
					exp = timestamp[(off % 8)*8 +: 8];
				else if (off % 8 == 4)
					exp = {7'd0, timestamp[32]};
				else
					exp = 8'h00;
				wb_access(1'b0, {PAGE_TIMESTAMP, byte_t'(off)}, 8'h00, q);
				if (!hung && q !== exp)
				begin
					$display("ERR timestamp expected %h actual %h", exp, q);
					errors++;
				end
			end
		end
		menu = 1'b0;
	endtask

	task automatic test_pause_menu();
		byte_t q;
		wb_write(ADDR_PAUSE, 8'h01);
		repeat (3) next_cycle();
		if (!hung && pause_system !== 1'b1)
		begin
			$display("ERR pause_set expected %h actual %h", 1'b1, pause_system);
			errors++;
		end
		pause = 1'b1;
		next_cycle();
		pause = 1'b0;
		next_cycle();
		if (!hung && pause_system !== 1'b0)
		begin
			$display("ERR pause_release expected %h actual %h", 1'b0, pause_system);
			errors++;
		end
		// clear whatever the input test left set, then request the menu
		wb_write(ADDR_MENU, 8'h00);
		menu = 1'b1;
		next_cycle();
		menu = 1'b0;
		wb_access(1'b0, ADDR_MENU, 8'h00, q);
		if (!hung && q !== 8'hFF)
		begin
			$display("ERR menu_set expected %h actual %h", 8'hFF, q);
			errors++;
		end
		wb_write(ADDR_MENU, 8'h00);
		wb_access(1'b0, ADDR_MENU, 8'h00, q);
		if (!hung && q !== 8'h00)
		begin
			$display("ERR menu_clear expected %h actual %h", 8'h00, q);
			errors++;
		end
	endtask

	task automatic test_timer();
		byte_t lo;
		byte_t hi;
		int t_clear;
		timer_t exp;
		wb_write({PAGE_TIMER, 8'h00}, 8'h00);
		t_clear = cycle_count;
		repeat (MS_DIVIDER * 7 / 2) next_cycle();
		exp = timer_t'((cycle_count - t_clear) / MS_DIVIDER);
		wb_access(1'b0, {PAGE_TIMER, 8'h00}, 8'h00, lo);
		wb_access(1'b0, {PAGE_TIMER, 8'h01}, 8'h00, hi);
		if (!hung && {hi, lo} !== exp)
		begin
			$display("ERR timer expected %h actual %h", exp, {hi, lo});
			errors++;
		end
	endtask

	task automatic test_mixer();
		byte_t ctl;
		rgb_t exp;
		for (int r = 0; r < 4; r++)
		begin
			ctl = byte_t'(rand_bits(8));
			wb_write(ADDR_VIDEO_CTL, ctl);
			for (int i = 0; i < 32; i++)
			begin
				char_pix = '{rgb: rgb_t'(rand_bits(24)), a: 1'(rand_bits(1))};
				sprite_pix = '{rgb: rgb_t'(rand_bits(24)), a: 1'(rand_bits(1))};
				tile_pix = '{rgb: rgb_t'(rand_bits(24)), a: 1'(rand_bits(1))};
				star_rgb = rgb_t'(rand_bits(24));
				exp = mix_model(ctl[0], char_pix, sprite_pix, tile_pix, star_rgb);
				next_cycle();
				if (!hung && video.rgb !== exp)
				begin
					$display("ERR mixer expected %h actual %h", exp, video.rgb);
					errors++;
				end
			end
		end
	endtask

	// counts over one frame, sampled 1 ns after each edge so ce_6 is settled
	task automatic test_raster();
		int n;
		int pulses;
		int line_pulses;
		int lines;
		int vis_h;
		int vis_v;
		int vis_both;
		int hs_cnt;
		int vs_cnt;
		logic found;
		logic line_started;
		logic prev_vs;
		logic prev_hs;
		if (hung)
			return;
		found = 1'b0;
		prev_vs = 1'b1;
		n = 0;
		while (!found && n < FRAME_TIMEOUT)
		begin
			@(posedge clk_24);
			#1;
			found = video.vs && !prev_vs;
			prev_vs = video.vs;
			n++;
		end
		if (!found)
		begin
			$display("timeout: no vertical sync seen at the video output");
			timeouts++;
			hung = 1'b1;
			return;
		end
		pulses = 0;
		line_pulses = 0;
		lines = 0;
		vis_h = 0;
		vis_v = 0;
		vis_both = 0;
		hs_cnt = 0;
		vs_cnt = 0;
		line_started = 1'b0;
		prev_hs = video.hs;
		found = 1'b0;
		n = 0;
		// runs until the next rising vs, which starts the following frame
		while (!found && n < FRAME_TIMEOUT)
		begin
			if (video.hs && !prev_hs)
			begin
				if (line_started && line_pulses != int'(H_TOTAL))
				begin
					$display("ERR line_length expected %0d actual %0d", int'(H_TOTAL),
						line_pulses);
					errors++;
				end
				line_started = 1'b1;
				line_pulses = 0;
				lines++;
			end
			prev_hs = video.hs;
			if (ce_6)
			begin
				pulses++;
				line_pulses++;
				vis_h += int'(!video.hb);
				vis_v += int'(!video.vb);
				vis_both += int'(!video.hb && !video.vb);
				hs_cnt += int'(video.hs);
				vs_cnt += int'(video.vs);
			end
			@(posedge clk_24);
			#1;
			n++;
			found = video.vs && !prev_vs;
			prev_vs = video.vs;
		end
		#1;
		if (!found)
		begin
			$display("timeout: no complete video frame seen");
			timeouts++;
			hung = 1'b1;
			return;
		end
		if (lines != int'(V_TOTAL) || pulses != int'(H_TOTAL) * int'(V_TOTAL))
		begin
			$display("ERR frame_size expected %0d %0d actual %0d %0d", int'(V_TOTAL),
				int'(H_TOTAL) * int'(V_TOTAL), lines, pulses);
			errors++;
		end
		if (vis_h != int'(H_VISIBLE) * int'(V_TOTAL) || vis_v != int'(V_VISIBLE) * int'(H_TOTAL))
		begin
			$display("ERR blanking expected %0d %0d actual %0d %0d",
				int'(H_VISIBLE) * int'(V_TOTAL), int'(V_VISIBLE) * int'(H_TOTAL), vis_h, vis_v);
			errors++;
		end
		if (vis_both != int'(H_VISIBLE) * int'(V_VISIBLE))
		begin
			$display("ERR visible_area expected %0d actual %0d",
				int'(H_VISIBLE) * int'(V_VISIBLE), vis_both);
			errors++;
		end
		if (hs_cnt != int'(H_SYNC_LEN) * int'(V_TOTAL) || vs_cnt != int'(V_SYNC_LEN) * int'(H_TOTAL))
		begin
			$display("ERR sync_width expected %0d %0d actual %0d %0d",
				int'(H_SYNC_LEN) * int'(V_TOTAL), int'(V_SYNC_LEN) * int'(H_TOTAL), hs_cnt, vs_cnt);
			errors++;
		end
	endtask

	initial
	begin
		lfsr = 32'haa894633;
		errors = 0;
		timeouts = 0;
		hung = 1'b0;
		ce_phase = 2'd0;
		ce_6 = 1'b0;
		rst = 1'b1;
		pause = 1'b0;
		menu = 1'b0;
		dn = '0;
		wb_in = '0;
		joystick = '0;
		ps2_key = '0;
		timestamp = '0;
		char_pix = '0;
		sprite_pix = '0;
		tile_pix = '0;
		star_rgb = '0;
		repeat (5) @(posedge clk_24);
		#2;
		rst = 1'b0;
		next_cycle();
		test_pgrom();
		test_wkram();
		test_inputs();
		test_pause_menu();
		test_timer();
		test_mixer();
		test_raster();
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- video/layer_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module layer_mixer (
	input wire logic clk_24,
	input wire logic rst,
	input wire aznable_pkg::raster_t raster,
	input wire aznable_pkg::layer_pix_t char_pix,
	input wire aznable_pkg::layer_pix_t sprite_pix,
	input wire aznable_pkg::layer_pix_t tile_pix,
	input wire aznable_pkg::rgb_t star_rgb,
	input wire logic sprite_high,
	output aznable_pkg::video_out_t video
);
	import aznable_pkg::*;

	rgb_t pix;

	// first opaque layer wins, starfield shows through everything else
	always_comb
	begin
		if (sprite_high && sprite_pix.a)
			pix = sprite_pix.rgb;
		else if (char_pix.a)
			pix = char_pix.rgb;
		else if (sprite_pix.a)
			pix = sprite_pix.rgb;
		else if (tile_pix.a)
			pix = tile_pix.rgb;
		else
			pix = star_rgb;
	end

	// syncs and blanks share the pixel register to stay aligned
	always_ff @(posedge clk_24)
	begin
		if (rst)
			video <= '0;
		else
			video <= '{hs: raster.hs, vs: raster.vs, hb: raster.hb, vb: raster.vb, rgb: pix};
	end

endmodule

`default_nettype wire

//--- video/video_timer.sv
`timescale 1ns/1ps
`default_nettype none

module video_timer (
	input wire logic clk_24,
	input wire logic rst,
	input wire logic ce_6,
	output aznable_pkg::raster_t raster
);
	import aznable_pkg::*;

	pos_t hcnt;
	pos_t vcnt;
	logic hs;
	logic vs;
	logic hb;
	logic vb;

	always_ff @(posedge clk_24)
	begin
		if (rst)
		begin
			hcnt <= '0;
			vcnt <= '0;
		end
		else if (ce_6)
		begin
			if (hcnt == H_TOTAL - 9'd1)
			begin
				hcnt <= '0;
				// next line, wrapping at the end of the frame
				if (vcnt == V_TOTAL - 9'd1)
					vcnt <= '0;
				else
					vcnt <= vcnt + 9'd1;
			end
			else
				hcnt <= hcnt + 9'd1;
		end
	end

	assign hb = hcnt >= H_VISIBLE;
	assign vb = vcnt >= V_VISIBLE;
	assign hs = (hcnt >= H_SYNC_START) && (hcnt < H_SYNC_START + H_SYNC_LEN);
	assign vs = (vcnt >= V_SYNC_START) && (vcnt < V_SYNC_START + V_SYNC_LEN);

	assign raster = '{hcnt: hcnt, vcnt: vcnt, hs: hs, vs: vs, hb: hb, vb: vb};

	hcnt_range: assert property (@(posedge clk_24) disable iff (rst) hcnt < H_TOTAL);

endmodule

`default_nettype wire
